/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // load/store opcodes
    typedef enum logic [3:0] {
        LD_B  = 4'd0,
        LD_BU = 4'd1,
        LD_H  = 4'd2,
        LD_HU = 4'd3,
        LD_W  = 4'd4,
        ST_B  = 4'd5,
        ST_H  = 4'd6,
        ST_W  = 4'd7,
        MOVE  = 4'd8
    } op_e;

    typedef logic [7:0] tag_t;  // returned untouched in the record

    // ex -> mem payload, 51 bits
    typedef struct packed {
        tag_t        tag;
        op_e         op;
        logic [4:0]  rd;
        logic [1:0]  lane;   // low address bits
        logic [31:0] value;  // base + offset, used by MOVE
    } ex_mem_t;

    // mem -> wb writeback record, 46 bits
    typedef struct packed {
        tag_t        tag;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] data;
    } wb_rec_t;

    // picks the byte or half out of the read word and extends it
    function automatic logic [31:0] extend_load(op_e op, logic [1:0] lane, logic [31:0] word);
        logic [7:0]  byte_sel;
        logic [15:0] half_sel;
        logic [31:0] result;
        byte_sel = word[{lane, 3'b000} +: 8];
        half_sel = lane[1] ? word[31:16] : word[15:0];  // lane[0] ignored for halves
        case (op)
            LD_B:    result = {{24{byte_sel[7]}}, byte_sel};
            LD_BU:   result = {24'b0, byte_sel};
            LD_H:    result = {{16{half_sel[15]}}, half_sel};
            LD_HU:   result = {16'b0, half_sel};
            default: result = word;  // full word
        endcase
        return result;
    endfunction

endpackage

`default_nettype wire

/* hdl/sram_if.sv */
`timescale 1ns/100ps
`default_nettype none

// data SRAM port, one access per cycle
interface sram_if #(
    parameter int ADDR_WIDTH = 8
) ();
    logic                  en;     // pulsed on the transfer cycle
    logic [3:0]            we;     // byte enables, zero means read
    logic [ADDR_WIDTH-1:0] addr;   // word address
    logic [31:0]           wdata;  // already shifted into its lanes
    logic [31:0]           rdata;  // registered, held until next read

    modport stage (
        output en, we, addr, wdata,
        input  rdata
    );

    modport memory (
        input  en, we, addr, wdata,
        output rdata
    );
endinterface

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_stage #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             in_req,
    output logic             in_ack,
    input  lsu_pkg::tag_t    in_tag,
    input  lsu_pkg::op_e     in_op,
    input  logic [4:0]       in_rd,
    input  logic [31:0]      in_base,
    input  logic [31:0]      in_offset,
    input  logic [31:0]      in_wdata,
    input  logic             mem_allowin,
    output logic             ex_valid,
    output lsu_pkg::ex_mem_t ex_bus,
    sram_if.stage            sram
);
    import lsu_pkg::*;

    tag_t                  ex_tag;
    op_e                   ex_op;
    logic [4:0]            ex_rd;
    logic [31:0]           ex_sum;    // full sum, MOVE result
    logic [31:0]           ex_wdata;
    logic [ADDR_WIDTH+1:0] ex_addr;   // masked byte address
    logic                  capture;
    logic                  ex_go;
    logic                  ex_is_load;
    logic                  ex_is_store;
    logic [31:0]           st_data;
    logic [3:0]            st_be;

    assign capture = in_req & ~in_ack & ~ex_valid;  // only when the holding reg is empty
    assign ex_go   = ex_valid & mem_allowin;

    // four-phase receiver, ack follows req down
    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_ack <= 1'b0;
        end else if (capture) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (capture) begin
            ex_valid <= 1'b1;
        end else if (ex_go) begin
            ex_valid <= 1'b0;  // handed to mem
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            ex_tag   <= in_tag;
            ex_op    <= in_op;
            ex_rd    <= in_rd;
            ex_sum   <= in_base + in_offset;
            ex_wdata <= in_wdata;
        end
    end

    assign ex_addr     = ex_sum[ADDR_WIDTH+1:0];
    assign ex_is_load  = ex_op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W};
    assign ex_is_store = ex_op inside {ST_B, ST_H, ST_W};

    // move store data into its lane and build the byte enables
    always_comb begin
        case (ex_op)
            ST_B: begin
                st_data = ex_wdata << {ex_addr[1:0], 3'b000};
                st_be   = 4'b0001 << ex_addr[1:0];
            end
            ST_H: begin
                st_data = ex_wdata << {ex_addr[1], 4'b0000};
                st_be   = ex_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data = ex_wdata;
                st_be   = 4'b1111;
            end
        endcase
    end

    assign sram.en    = ex_go & (ex_is_load | ex_is_store);  // MOVE leaves the SRAM alone
    assign sram.we    = ex_is_store ? st_be : 4'b0000;
    assign sram.addr  = ex_addr[ADDR_WIDTH+1:2];
    assign sram.wdata = st_data;

    assign ex_bus = '{tag: ex_tag, op: ex_op, rd: ex_rd, lane: ex_addr[1:0], value: ex_sum};
endmodule

`default_nettype wire

/* hdl/data_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_sram #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic   clk,
    sram_if.memory mem
);
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [31:0] ram [0:DEPTH-1];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            ram[i] = 32'b0;
        end
    end

    // byte-enabled write
    always_ff @(posedge clk) begin
        if (mem.en) begin
            for (int b = 0; b < 4; b++) begin
                if (mem.we[b]) begin
                    ram[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
                end
            end
        end
    end

    // read port, rdata holds between reads
    always_ff @(posedge clk) begin
        if (mem.en && mem.we == 4'b0000) begin
            mem.rdata <= ram[mem.addr];
        end
    end
endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  logic             clk,
    input  logic             resetn,
    input  logic             ex_valid,
    input  lsu_pkg::ex_mem_t ex_bus,
    input  logic [31:0]      rdata,
    input  logic             wb_allowin,
    output logic             mem_allowin,
    output logic             mem_valid_out,
    output lsu_pkg::wb_rec_t mem_bus
);
    import lsu_pkg::*;

    logic        mem_valid;
    ex_mem_t     mem_r;      // registered operation
    logic        mem_is_load;
    logic        mem_we;
    logic [31:0] mem_data;

    // rdata is ready the cycle after the transfer and stays put,
    // so the stage never has to wait
    assign mem_allowin   = ~mem_valid | wb_allowin;
    assign mem_valid_out = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && mem_allowin) begin
            mem_r <= ex_bus;
        end
    end

    assign mem_is_load = mem_r.op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W};

    always_comb begin
        if (mem_is_load) begin
            mem_data = extend_load(mem_r.op, mem_r.lane, rdata);
            mem_we   = 1'b1;
        end else if (mem_r.op == MOVE) begin
            mem_data = mem_r.value;
            mem_we   = 1'b1;
        end else begin
            mem_data = 32'b0;   // stores write nothing back
            mem_we   = 1'b0;
        end
    end

    assign mem_bus = '{tag: mem_r.tag, rd: mem_r.rd, we: mem_we, data: mem_data};
endmodule

`default_nettype wire

/* hdl/wb_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
    input  logic             clk,
    input  logic             resetn,
    input  logic             mem_valid_out,
    input  lsu_pkg::wb_rec_t mem_bus,
    input  logic             out_ack,
    output logic             wb_allowin,
    output logic             out_req,
    output lsu_pkg::tag_t    out_tag,
    output logic [4:0]       out_rd,
    output logic             out_we,
    output logic [31:0]      out_data
);
    import lsu_pkg::*;

    // four-phase sender states
    typedef enum logic [1:0] {
        WB_EMPTY = 2'd0,
        WB_LOAD  = 2'd1,   // record held, req goes up next
        WB_REQ   = 2'd2,   // req high, waiting for ack
        WB_WAIT  = 2'd3    // req low, waiting for ack to fall
    } wb_state_e;

    wb_state_e state;
    wb_rec_t   wb_r;

    assign wb_allowin = (state == WB_EMPTY);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= WB_EMPTY;
        end else begin
            case (state)
                WB_EMPTY: if (mem_valid_out) state <= WB_LOAD;
                WB_LOAD:  state <= WB_REQ;
                WB_REQ:   if (out_ack) state <= WB_WAIT;
                WB_WAIT:  if (!out_ack) state <= WB_EMPTY;  // freed on ack fall
                default:  state <= WB_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid_out && wb_allowin) begin
            wb_r <= mem_bus;
        end
    end

    assign out_req  = (state == WB_REQ);
    assign out_tag  = wb_r.tag;
    assign out_rd   = wb_r.rd;
    assign out_we   = wb_r.we;
    assign out_data = wb_r.data;
endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic          clk,
    input  logic          resetn,
    input  logic          in_req,
    output logic          in_ack,
    input  lsu_pkg::tag_t in_tag,
    input  lsu_pkg::op_e  in_op,
    input  logic [4:0]    in_rd,
    input  logic [31:0]   in_base,
    input  logic [31:0]   in_offset,
    input  logic [31:0]   in_wdata,
    output logic          out_req,
    input  logic          out_ack,
    output lsu_pkg::tag_t out_tag,
    output logic [4:0]    out_rd,
    output logic          out_we,
    output logic [31:0]   out_data
);
    import lsu_pkg::*;

    logic    ex_valid;
    ex_mem_t ex_bus;
    logic    mem_allowin;
    logic    mem_valid_out;
    wb_rec_t mem_bus;
    logic    wb_allowin;

    sram_if #(.ADDR_WIDTH(ADDR_WIDTH)) sram ();

    ex_stage #(.ADDR_WIDTH(ADDR_WIDTH)) u_ex (
        .clk         (clk),
        .resetn      (resetn),
        .in_req      (in_req),
        .in_ack      (in_ack),
        .in_tag      (in_tag),
        .in_op       (in_op),
        .in_rd       (in_rd),
        .in_base     (in_base),
        .in_offset   (in_offset),
        .in_wdata    (in_wdata),
        .mem_allowin (mem_allowin),
        .ex_valid    (ex_valid),
        .ex_bus      (ex_bus),
        .sram        (sram)
    );

    data_sram #(.ADDR_WIDTH(ADDR_WIDTH)) u_sram (
        .clk (clk),
        .mem (sram)
    );

    mem_stage u_mem (
        .clk           (clk),
        .resetn        (resetn),
        .ex_valid      (ex_valid),
        .ex_bus        (ex_bus),
        .rdata         (sram.rdata),    // straight from the SRAM output reg
        .wb_allowin    (wb_allowin),
        .mem_allowin   (mem_allowin),
        .mem_valid_out (mem_valid_out),
        .mem_bus       (mem_bus)
    );

    wb_stage u_wb (
        .clk           (clk),
        .resetn        (resetn),
        .mem_valid_out (mem_valid_out),
        .mem_bus       (mem_bus),
        .out_ack       (out_ack),
        .wb_allowin    (wb_allowin),
        .out_req       (out_req),
        .out_tag       (out_tag),
        .out_rd        (out_rd),
        .out_we        (out_we),
        .out_data      (out_data)
    );
endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

// free-running clock plus a reset held low for a few cycles
module tb_clock #(
    parameter real PERIOD       = 20.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;  // released on an edge like any other input
    end
endmodule

`default_nettype wire

/* bench/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int MAX_ROWS  = 64;
    localparam int ROW_WORDS = 8;   // tag op rd base offset wdata we data

    logic        clk;
    logic        resetn;
    logic        in_req;
    logic        in_ack;
    tag_t        in_tag;
    op_e         in_op;
    logic [4:0]  in_rd;
    logic [31:0] in_base;
    logic [31:0] in_offset;
    logic [31:0] in_wdata;
    logic        out_req;
    logic        out_ack;
    tag_t        out_tag;
    logic [4:0]  out_rd;
    logic        out_we;
    logic [31:0] out_data;

    logic [31:0] gold [0:MAX_ROWS*ROW_WORDS-1];
    int          n_rows   = 0;
    int          n_sent   = 0;
    int          n_recv   = 0;
    int          n_errors = 0;
    logic [31:0] in_seed;
    logic [31:0] out_seed;

    tb_clock #(.PERIOD(20.0), .RESET_CYCLES(3)) u_clock (.clk(clk), .resetn(resetn));

    lsu_top #(.ADDR_WIDTH(8)) DUT (
        .clk       (clk),
        .resetn    (resetn),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_tag    (in_tag),
        .in_op     (in_op),
        .in_rd     (in_rd),
        .in_base   (in_base),
        .in_offset (in_offset),
        .in_wdata  (in_wdata),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_tag   (out_tag),
        .out_rd    (out_rd),
        .out_we    (out_we),
        .out_data  (out_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // record the golden row promises for this position
    function automatic wb_rec_t expected_rec(input int row);
        wb_rec_t r;
        r.tag  = gold[row*ROW_WORDS][7:0];
        r.rd   = gold[row*ROW_WORDS+2][4:0];
        r.we   = gold[row*ROW_WORDS+6][0];
        r.data = gold[row*ROW_WORDS+7];
        return r;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rec(input wb_rec_t got, input wb_rec_t exp);
        int bad;
        bad = 0;
        if (got.tag !== exp.tag) begin
            $display("MISMATCH out_tag: got %h expected %h", got.tag, exp.tag);
            bad++;
        end
        if (got.rd !== exp.rd) begin
            $display("MISMATCH out_rd (tag %h): got %h expected %h", exp.tag, got.rd, exp.rd);
            bad++;
        end
        if (got.we !== exp.we) begin
            $display("MISMATCH out_we (tag %h): got %h expected %h", exp.tag, got.we, exp.we);
            bad++;
        end
        if (got.data !== exp.data) begin
            $display("MISMATCH out_data (tag %h): got %h expected %h",
                     exp.tag, got.data, exp.data);
            bad++;
        end
        if (bad != 0) begin
            n_errors += bad;
            abort_run();
        end
    endtask

    task automatic check_idle(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s at %0t: got %h expected %h", name, $time, got, exp);
            n_errors++;
            abort_run();
        end
    endtask

    // empty slots carry a marker above the tag range
    task automatic load_golden();
        for (int i = 0; i < MAX_ROWS*ROW_WORDS; i++) begin
            gold[i] = {16'hdead, i[15:0]};
        end
        $readmemh("bench/lsu_golden.txt", gold);
        while (n_rows < MAX_ROWS && gold[n_rows*ROW_WORDS][31:8] == '0) begin
            n_rows++;
        end
    endtask

    // four-phase source, data held until ack falls
    task automatic send_op(input int row);
        int idx;
        idx = row * ROW_WORDS;
        in_tag    <= gold[idx][7:0];
        in_op     <= op_e'(gold[idx+1][3:0]);
        in_rd     <= gold[idx+2][4:0];
        in_base   <= gold[idx+3];
        in_offset <= gold[idx+4];
        in_wdata  <= gold[idx+5];
        in_req    <= 1'b1;
        do begin
            @(posedge clk);
        end while (!in_ack);
        in_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (in_ack);
        n_sent++;
    endtask

    // input driver
    initial begin
        in_req    = 1'b0;
        in_tag    = '0;
        in_op     = LD_W;
        in_rd     = '0;
        in_base   = '0;
        in_offset = '0;
        in_wdata  = '0;
        in_seed   = 32'd86094;
        load_golden();
        if (n_rows == 0) begin
            $display("the golden file holds no stimulus rows");
            abort_run();
        end
        wait (resetn === 1'b1);
        @(posedge clk);
        check_idle("in_ack", in_ack, 1'b0);
        check_idle("out_req", out_req, 1'b0);
        for (int row = 0; row < n_rows; row++) begin
            in_seed = xorshift(in_seed);
            repeat (in_seed % 4) @(posedge clk);  // idle gap
            send_op(row);
        end
    end

    // output sink with random ack timing
    initial begin
        wb_rec_t got;
        int      delay;
        out_ack  = 1'b0;
        out_seed = xorshift(32'd86094);
        forever begin
            @(posedge clk);
            if (out_req && !out_ack) begin
                if (n_recv >= n_rows) begin
                    $display("extra record with tag %h after the last operation", out_tag);
                    n_errors++;
                    abort_run();
                end
                got = '{tag: out_tag, rd: out_rd, we: out_we, data: out_data};
                check_rec(got, expected_rec(n_recv));  // in input order
                n_recv++;
                out_seed = xorshift(out_seed);
                delay = int'(out_seed % 8);
                repeat (delay) @(posedge clk);
                out_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (out_req);
                out_seed = xorshift(out_seed);
                delay = int'(out_seed % 4);
                repeat (delay) @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    end

    // end of run
    initial begin
        wait (n_rows > 0);
        wait (n_recv == n_rows && n_sent == n_rows);
        repeat (20) @(posedge clk);  // room for a stray record
        check_idle("out_req", out_req, 1'b0);
        check_idle("in_ack", in_ack, 1'b0);
        if (n_errors == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run();
        end
    end

    // watchdog
    initial begin
        wait (n_rows > 0);
        repeat (n_rows * 200) @(posedge clk);
        $display("timeout: %0d of %0d records back after %0d cycles",
                 n_recv, n_rows, n_rows * 200);
        abort_run();
    end
endmodule

`default_nettype wire

/* bench/lsu_golden.txt */
// tag op rd base offset wdata | expected we data (hex)
// op: 0 LD_B 1 LD_BU 2 LD_H 3 LD_HU 4 LD_W 5 ST_B 6 ST_H 7 ST_W 8 MOVE
01 7 00 00000100 00000000 12f07f81 0 00000000
02 4 01 00000100 00000000 00000000 1 12f07f81
03 8 02 00001000 00000234 00000000 1 00001234
04 0 03 00000100 00000000 00000000 1 ffffff81
05 0 04 00000100 00000001 00000000 1 0000007f
06 0 05 00000100 00000002 00000000 1 fffffff0
07 0 06 00000100 00000003 00000000 1 00000012
08 1 07 00000100 00000000 00000000 1 00000081
09 1 08 00000100 00000001 00000000 1 0000007f
0a 1 09 00000100 00000002 00000000 1 000000f0
0b 1 0a 00000100 00000003 00000000 1 00000012
0c 7 00 00000104 00000000 9abc1234 0 00000000
0d 2 0b 00000104 00000000 00000000 1 00001234
0e 2 0c 00000104 00000002 00000000 1 ffff9abc
0f 3 0d 00000104 00000000 00000000 1 00001234
10 3 0e 00000104 00000002 00000000 1 00009abc
11 5 00 00000104 00000001 000000ee 0 00000000
12 6 00 00000104 00000002 00005566 0 00000000
13 4 0f 00000104 00000000 00000000 1 5566ee34
14 5 00 00000100 00000003 000000a5 0 00000000
15 4 10 00000100 00000000 00000000 1 a5f07f81
16 8 11 00000010 fffffff0 00000000 1 00000000
17 4 12 00000000 00000100 00000000 1 a5f07f81
18 0 13 00000105 00000000 00000000 1 ffffffee
19 3 14 10000104 00000002 00000000 1 00005566

/* list.f */
hdl/lsu_pkg.sv
hdl/sram_if.sv
hdl/ex_stage.sv
hdl/data_sram.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/lsu_top.sv
bench/tb_clock.sv
bench/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := lsu_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || \
		(echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
